// File: common/ddr_settings.svh
`ifndef DDR_SETTINGS_SVH
`define DDR_SETTINGS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------

// Command address, counted in 128-bit words
`define DDR_ADDR_W 28

// One data beat
`define DDR_DATA_W 128

// One enable bit per byte of a beat
`define DDR_BE_W 16

// ----------------------------------------------------------------------
// Burst and storage shape
// ----------------------------------------------------------------------

// Beats per burst
`define DDR_BURST_LEN 2

// Words held on chip, addresses alias modulo this
`define DDR_MEM_WORDS 256

// Accept cycle to first read beat, at least 2
`define DDR_RD_LAT 2

// Command count width
`define DDR_CNT_W 8

`endif

// File: common/ddr_pkg.sv
`include "ddr_settings.svh"

package ddr_pkg;

   // ----------------------------------------------------------------------
   // Data path types
   // ----------------------------------------------------------------------

   // One beat, byte i sits in bits [8*i+7 : 8*i]
   typedef logic [`DDR_DATA_W-1:0] ddr_word_t;

   // Bit i enables byte i of the beat
   typedef logic [`DDR_BE_W-1:0] ddr_be_t;

   // Word address as seen on the command bus
   typedef logic [`DDR_ADDR_W-1:0] ddr_addr_t;

   // Number of bursts in one start request
   typedef logic [`DDR_CNT_W-1:0] cmd_cnt_t;

   // ----------------------------------------------------------------------
   // State encodings
   // ----------------------------------------------------------------------

   // Controller FSM
   typedef enum logic [1:0] {
      ctrl_idle    = 2'd0,
      ctrl_wr_beat = 2'd1,
      ctrl_rd_wait = 2'd2,
      ctrl_rd_beat = 2'd3
   } ctrl_state_t;

   // Sequencer FSM
   typedef enum logic [1:0] {
      gen_idle  = 2'd0,
      gen_issue = 2'd1,
      gen_wait  = 2'd2
   } gen_state_t;

endpackage

// File: ddr_ctrl/ddr_store.sv
`timescale 1ns/100ps
`include "ddr_settings.svh"

module ddr_store
   import ddr_pkg::*;
(
   input  logic                              CLK,
   input  logic                              wr_en,
   input  logic [$clog2(`DDR_MEM_WORDS)-1:0] wr_idx,
   input  ddr_word_t                         wr_data,
   input  ddr_be_t                           wr_be,
   input  logic                              rd_en,
   input  logic [$clog2(`DDR_MEM_WORDS)-1:0] rd_idx,
   output ddr_word_t                         rd_data
);

   // ----------------------------------------------------------------------
   // Storage array
   // ----------------------------------------------------------------------

   // One beat per word
   ddr_word_t mem [`DDR_MEM_WORDS];

   // Byte-masked write
   always_ff @(posedge CLK)
   begin
      if (wr_en)
      begin
         for (int i = 0; i < `DDR_BE_W; i++)
         begin
            // Untouched bytes keep their old value
            if (wr_be[i])
               mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
         end
      end
   end

   // ----------------------------------------------------------------------
   // Registered read
   // ----------------------------------------------------------------------

   // Data shows up the cycle after rd_en and holds until the next read
   always_ff @(posedge CLK)
   begin
      if (rd_en)
         rd_data <= mem[rd_idx];
   end

endmodule

// File: ddr_ctrl/ddr_ctrl.sv
`timescale 1ns/100ps
`include "ddr_settings.svh"

module ddr_ctrl
   import ddr_pkg::*;
(
   input  logic      CLK,
   input  logic      rst,
   input  logic      cmd_wr,
   input  logic      cmd_rd,
   input  ddr_addr_t cmd_addr,
   input  ddr_word_t din,
   input  ddr_be_t   be,
   output logic      ddr_ready,
   output logic      din_req,
   output ddr_word_t dout,
   output logic      dout_valid
);

   localparam int IDX_W  = $clog2(`DDR_MEM_WORDS);
   localparam int BEAT_W = $clog2(`DDR_BURST_LEN);
   localparam int LAT_W  = $clog2(`DDR_RD_LAT + 1);

   ctrl_state_t       state;
   logic              clearing;
   logic [IDX_W-1:0]  clr_idx;
   logic [BEAT_W-1:0] beat;
   logic [LAT_W-1:0]  lat_cnt;
   ddr_addr_t         base_addr;
   ddr_addr_t         beat_addr;
   logic [IDX_W-1:0]  beat_idx;
   logic              accept;
   logic              last_beat;
   logic              rd_en;
   logic              st_wr_en;
   logic [IDX_W-1:0]  st_wr_idx;
   ddr_word_t         st_wr_data;
   ddr_be_t           st_wr_be;

   // ----------------------------------------------------------------------
   // Handshake and address folding
   // ----------------------------------------------------------------------

   // Busy while sweeping, inside a burst, or while read beats drain
   assign ddr_ready = (state == ctrl_idle) && !clearing && !dout_valid;
   assign accept    = (cmd_wr || cmd_rd) && ddr_ready;

   assign last_beat = (beat == BEAT_W'(`DDR_BURST_LEN - 1));

   // Beat address, low bits pick the word so addresses alias
   assign beat_addr = base_addr + ddr_addr_t'(beat);
   assign beat_idx  = beat_addr[IDX_W-1:0];

   assign din_req = (state == ctrl_wr_beat);
   assign rd_en   = (state == ctrl_rd_beat);

   // ----------------------------------------------------------------------
   // Clear sweep after reset
   // ----------------------------------------------------------------------

   always_ff @(posedge CLK)
   begin
      if (rst)
      begin
         clearing <= 1'b1;
         clr_idx  <= '0;
      end
      else if (clearing)
      begin
         clr_idx <= clr_idx + IDX_W'(1);
         // One word per cycle, done after the top word
         if (clr_idx == IDX_W'(`DDR_MEM_WORDS - 1))
            clearing <= 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // Controller FSM
   // ----------------------------------------------------------------------

   always_ff @(posedge CLK)
   begin
      if (rst)
      begin
         state   <= ctrl_idle;
         beat    <= '0;
         lat_cnt <= '0;
      end
      else
      begin
         case (state)
            ctrl_idle:
            begin
               beat <= '0;
               if (accept && cmd_wr)
                  state <= ctrl_wr_beat;
               else if (accept)
               begin
                  // Store read adds one cycle, wait out the rest
                  lat_cnt <= LAT_W'(`DDR_RD_LAT - 2);
                  state   <= (`DDR_RD_LAT > 2) ? ctrl_rd_wait : ctrl_rd_beat;
               end
            end
            ctrl_rd_wait:
            begin
               lat_cnt <= lat_cnt - LAT_W'(1);
               if (lat_cnt == LAT_W'(1))
                  state <= ctrl_rd_beat;
            end
            ctrl_wr_beat, ctrl_rd_beat:
            begin
               beat <= beat + BEAT_W'(1);
               if (last_beat)
                  state <= ctrl_idle;
            end
            default:
               state <= ctrl_idle;
         endcase
      end
   end

   // Burst base, only meaningful once accepted
   always_ff @(posedge CLK)
   begin
      if (accept)
         base_addr <= cmd_addr;
   end

   // Read data lands one cycle after each store read
   always_ff @(posedge CLK)
   begin
      if (rst)
         dout_valid <= 1'b0;
      else
         dout_valid <= rd_en;
   end

   // ----------------------------------------------------------------------
   // Storage
   // ----------------------------------------------------------------------

   // Sweep writes zeros with every byte enabled
   assign st_wr_en   = clearing || din_req;
   assign st_wr_idx  = clearing ? clr_idx : beat_idx;
   assign st_wr_data = clearing ? '0 : din;
   assign st_wr_be   = clearing ? '1 : be;

   ddr_store u_store (
      .CLK     (CLK),
      .wr_en   (st_wr_en),
      .wr_idx  (st_wr_idx),
      .wr_data (st_wr_data),
      .wr_be   (st_wr_be),
      .rd_en   (rd_en),
      .rd_idx  (beat_idx),
      .rd_data (dout)
   );

   // ----------------------------------------------------------------------
   // Protocol checks
   // ----------------------------------------------------------------------

   a_cmd_only_when_ready : assert property (@(posedge CLK) disable iff (rst)
      (cmd_wr || cmd_rd) |-> ddr_ready);

   a_no_data_overlap : assert property (@(posedge CLK) disable iff (rst)
      !(din_req && dout_valid));

   // Write accept gives exactly the burst of din_req cycles
   a_wr_beats : assert property (@(posedge CLK) disable iff (rst)
      (cmd_wr && ddr_ready) |=> din_req [*`DDR_BURST_LEN] ##1 !din_req);

endmodule

// File: cmd_gen/cmd_gen.sv
`timescale 1ns/100ps
`include "ddr_settings.svh"

module cmd_gen
   import ddr_pkg::*;
(
   input  logic      CLK,
   input  logic      rst,
   input  logic      start_wr,
   input  logic      start_rd,
   input  cmd_cnt_t  num_cmds,
   input  ddr_addr_t start_addr,
   input  logic      ddr_ready,
   output logic      cmd_wr,
   output logic      cmd_rd,
   output ddr_addr_t cmd_addr,
   output logic      busy,
   output logic      done
);

   gen_state_t state;
   logic       is_wr;
   cmd_cnt_t   remaining;
   ddr_addr_t  run_addr;
   logic       start;
   logic       fire;

   // ----------------------------------------------------------------------
   // Strobes and status
   // ----------------------------------------------------------------------

   assign start = start_wr || start_rd;

   // Only fire while the controller is ready, so every strobe lands
   assign fire = (state == gen_issue) && ddr_ready;

   assign cmd_wr   = fire && is_wr;
   assign cmd_rd   = fire && !is_wr;
   assign cmd_addr = run_addr;

   assign busy = (state != gen_idle);

   // Ready back after the last burst means its final beat is done
   assign done = (state == gen_wait) && (remaining == '0) && ddr_ready;

   // ----------------------------------------------------------------------
   // Sequencer FSM
   // ----------------------------------------------------------------------

   always_ff @(posedge CLK)
   begin
      if (rst)
      begin
         state     <= gen_idle;
         is_wr     <= 1'b0;
         remaining <= '0;
      end
      else
      begin
         case (state)
            gen_idle:
            begin
               if (start)
               begin
                  is_wr     <= start_wr;
                  remaining <= num_cmds;
                  // Zero count goes straight to the done check
                  state     <= (num_cmds == '0) ? gen_wait : gen_issue;
               end
            end
            gen_issue:
            begin
               if (ddr_ready)
               begin
                  remaining <= remaining - cmd_cnt_t'(1);
                  state     <= gen_wait;
               end
            end
            gen_wait:
            begin
               // Hold here while the burst is in flight
               if (ddr_ready)
                  state <= (remaining == '0) ? gen_idle : gen_issue;
            end
            default:
               state <= gen_idle;
         endcase
      end
   end

   // Running burst address
   always_ff @(posedge CLK)
   begin
      if ((state == gen_idle) && start)
         run_addr <= start_addr;
      else if (fire)
         run_addr <= run_addr + ddr_addr_t'(`DDR_BURST_LEN);
   end

   // ----------------------------------------------------------------------
   // Checks on the start interface
   // ----------------------------------------------------------------------

   a_start_when_idle : assert property (@(posedge CLK) disable iff (rst)
      start |-> !busy);

   a_start_one_kind : assert property (@(posedge CLK) disable iff (rst)
      !(start_wr && start_rd));

endmodule

// File: hw/ddr_subsys.sv
`timescale 1ns/100ps

module ddr_subsys
   import ddr_pkg::*;
(
   input  logic      CLK,
   input  logic      rst,
   input  logic      start_wr,
   input  logic      start_rd,
   input  cmd_cnt_t  num_cmds,
   input  ddr_addr_t start_addr,
   output logic      busy,
   output logic      done,
   input  ddr_word_t din,
   input  ddr_be_t   be,
   output logic      din_req,
   output ddr_word_t dout,
   output logic      dout_valid
);

   // ----------------------------------------------------------------------
   // Command bus between sequencer and controller
   // ----------------------------------------------------------------------

   logic      cmd_wr;
   logic      cmd_rd;
   ddr_addr_t cmd_addr;
   logic      ddr_ready;

   // Turns one start strobe into a run of bursts
   cmd_gen u_cmd_gen (
      .CLK        (CLK),
      .rst        (rst),
      .start_wr   (start_wr),
      .start_rd   (start_rd),
      .num_cmds   (num_cmds),
      .start_addr (start_addr),
      .ddr_ready  (ddr_ready),
      .cmd_wr     (cmd_wr),
      .cmd_rd     (cmd_rd),
      .cmd_addr   (cmd_addr),
      .busy       (busy),
      .done       (done)
   );

   // Burst engine with on-chip storage
   ddr_ctrl u_ddr_ctrl (
      .CLK        (CLK),
      .rst        (rst),
      .cmd_wr     (cmd_wr),
      .cmd_rd     (cmd_rd),
      .cmd_addr   (cmd_addr),
      .din        (din),
      .be         (be),
      .ddr_ready  (ddr_ready),
      .din_req    (din_req),
      .dout       (dout),
      .dout_valid (dout_valid)
   );

endmodule

// File: verification/ddr_checker.sv
`timescale 1ns/100ps
`include "ddr_settings.svh"

module ddr_checker
   import ddr_pkg::*;
(
   input  logic      CLK,
   input  logic      rst,
   input  logic      start_wr,
   input  logic      start_rd,
   input  cmd_cnt_t  num_cmds,
   input  ddr_addr_t start_addr,
   input  logic      busy,
   input  logic      done,
   input  ddr_word_t din,
   input  ddr_be_t   be,
   input  logic      din_req,
   input  ddr_word_t dout,
   input  logic      dout_valid,
   output int        checks,
   output int        value_errs,
   output int        proto_errs
);

   // Shadow of the on-chip array
   // Cleared on reset to match the swept store
   ddr_word_t shadow [`DDR_MEM_WORDS];

   // Request in flight as taken from the start strobe
   logic      active;
   logic      req_wr;
   cmd_cnt_t  req_n;
   ddr_addr_t req_base;
   int        wr_beats;
   int        rd_beats;
   int        since_rst;
   logic      seen_data;

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------

   // Addresses alias modulo the array depth
   function automatic int word_index(ddr_addr_t addr);
      return int'(addr % ddr_addr_t'(`DDR_MEM_WORDS));
   endfunction

   // Only enabled bytes take the new data
   function automatic ddr_word_t merge_bytes(ddr_word_t old_word, ddr_word_t new_word,
                                             ddr_be_t mask);
      ddr_word_t res;
      res = old_word;
      for (int i = 0; i < `DDR_BE_W; i++)
      begin
         if (mask[i])
            res[8*i +: 8] = new_word[8*i +: 8];
      end
      return res;
   endfunction

   // Beat a read of this address should return
   function automatic ddr_word_t expected_beat(ddr_addr_t addr);
      return shadow[word_index(addr)];
   endfunction

   task automatic check_value(string name, ddr_word_t exp, ddr_word_t act);
      checks++;
      if (act !== exp)
      begin
         value_errs++;
         $display("error %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic flag_protocol(string what);
      proto_errs++;
      $display("Protocol failure at %0t: %s", $time, what);
   endtask

   // ----------------------------------------------------------------------
   // Compare process at mid-cycle where everything is settled
   // ----------------------------------------------------------------------

   always @(negedge CLK)
   begin : cycle_check
      ddr_addr_t addr;
      if (rst)
      begin
         checks     = 0;
         value_errs = 0;
         proto_errs = 0;
         active     = 1'b0;
         since_rst  = 0;
         seen_data  = 1'b0;
         for (int i = 0; i < `DDR_MEM_WORDS; i++)
            shadow[i] = '0;
      end
      else
      begin
         since_rst++;
         // Quiet outputs right out of reset
         if (since_rst == 1)
         begin
            check_value("done", ddr_word_t'(1'b0), ddr_word_t'(done));
            check_value("din_req", ddr_word_t'(1'b0), ddr_word_t'(din_req));
            check_value("dout_valid", ddr_word_t'(1'b0), ddr_word_t'(dout_valid));
         end
         // Busy from the cycle after start up to and including done
         check_value("busy", ddr_word_t'(active), ddr_word_t'(busy));
         if (start_wr || start_rd)
         begin
            if (active)
               flag_protocol("start strobe arrived while a request was still running");
            active   = 1'b1;
            req_wr   = start_wr;
            req_n    = num_cmds;
            req_base = start_addr;
            wr_beats = 0;
            rd_beats = 0;
         end
         // Nothing moves on the data side until the sweep and the first accept are over
         if ((din_req || dout_valid) && !seen_data)
         begin
            seen_data = 1'b1;
            if (since_rst <= `DDR_MEM_WORDS + 1)
               flag_protocol("data strobe came before the clear sweep had finished");
         end
         if (din_req)
         begin
            if (!active || !req_wr)
               flag_protocol("din_req raised outside a write request");
            else
            begin
               // Beat n of a request lands at start plus n
               addr = req_base + ddr_addr_t'(wr_beats);
               shadow[word_index(addr)] = merge_bytes(expected_beat(addr), din, be);
               wr_beats++;
            end
         end
         if (dout_valid)
         begin
            if (!active || req_wr)
               flag_protocol("dout_valid raised outside a read request");
            else
            begin
               addr = req_base + ddr_addr_t'(rd_beats);
               check_value("dout", expected_beat(addr), dout);
               rd_beats++;
            end
         end
         if (done)
         begin
            if (!active)
               flag_protocol("done pulsed with no request running");
            else if (req_wr)
               check_value("din_req beats", ddr_word_t'(`DDR_BURST_LEN * int'(req_n)),
                           ddr_word_t'(wr_beats));
            else
               check_value("dout_valid beats", ddr_word_t'(`DDR_BURST_LEN * int'(req_n)),
                           ddr_word_t'(rd_beats));
            active = 1'b0;
         end
      end
   end

endmodule

// File: verification/ddr_subsys_tb.sv
`timescale 1ns/100ps
`include "ddr_settings.svh"

module ddr_subsys_tb
   import ddr_pkg::*;
();

   logic      CLK;
   logic      rst;
   logic      start_wr;
   logic      start_rd;
   cmd_cnt_t  num_cmds;
   ddr_addr_t start_addr;
   logic      busy;
   logic      done;
   ddr_word_t din;
   ddr_be_t   be;
   logic      din_req;
   ddr_word_t dout;
   logic      dout_valid;
   int        checks;
   int        value_errs;
   int        proto_errs;
   int        budget_cycles = 0;

   // Request plan, one entry per start strobe
   logic      plan_wr[$];
   cmd_cnt_t  plan_n[$];
   ddr_addr_t plan_addr[$];

   ddr_subsys u_dut (.*);

   // Watches the same wires and keeps the shadow memory
   ddr_checker u_chk (.*);

   // ----------------------------------------------------------------------
   // Clock, data source, watchdog
   // ----------------------------------------------------------------------

   initial
   begin
      CLK = 1'b0;
      forever
         #20 CLK = ~CLK;
   end

   // Fresh random beat and enables for every din_req cycle
   initial
   begin
      din = '0;
      be  = '0;
      forever
      begin
         @(posedge CLK);
         #2;
         if (din_req)
         begin
            din = {$urandom, $urandom, $urandom, $urandom};
            be  = ddr_be_t'($urandom);
         end
      end
   end

   initial
   begin
      wait (budget_cycles > 0);
      repeat (budget_cycles) @(posedge CLK);
      $display("Watchdog: run hung, last done not seen within %0d cycles", budget_cycles);
      $display("STATUS: FAIL");
      $finish;
   end

   // ----------------------------------------------------------------------
   // Request helpers
   // ----------------------------------------------------------------------

   task automatic add_req(input logic is_wr, input cmd_cnt_t n, input ddr_addr_t addr);
      plan_wr.push_back(is_wr);
      plan_n.push_back(n);
      plan_addr.push_back(addr);
   endtask

   // One start strobe, then wait for done
   task automatic run_request(input logic is_wr, input cmd_cnt_t n, input ddr_addr_t addr);
      @(posedge CLK);
      #2;
      start_wr   = is_wr;
      start_rd   = !is_wr;
      num_cmds   = n;
      start_addr = addr;
      @(posedge CLK);
      #2;
      start_wr = 1'b0;
      start_rd = 1'b0;
      @(negedge CLK);
      while (!done)
         @(negedge CLK);
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------

   initial
   begin
      cmd_cnt_t  n;
      ddr_addr_t a;
      int        budget;
      rst        = 1'b1;
      start_wr   = 1'b0;
      start_rd   = 1'b0;
      num_cmds   = '0;
      start_addr = '0;
      void'($urandom(32'hef12));

      // Untouched words, issued before the sweep ends
      add_req(1'b0, 8'd2, 28'h0000040);
      // Single burst written then read back
      add_req(1'b1, 8'd1, 28'h0000020);
      add_req(1'b0, 8'd1, 28'h0000020);
      // Random runs anywhere in the address space
      for (int i = 0; i < 6; i++)
      begin
         n = cmd_cnt_t'($urandom_range(8, 1));
         a = ddr_addr_t'($urandom);
         add_req(1'b1, n, a);
         add_req(1'b0, n, a);
      end
      // Overwrite with random enables, old bytes show through
      add_req(1'b1, 8'd3, 28'h0000090);
      add_req(1'b1, 8'd3, 28'h0000090);
      add_req(1'b0, 8'd3, 28'h0000090);
      // Empty requests
      add_req(1'b1, 8'd0, 28'h0000010);
      add_req(1'b0, 8'd0, 28'h0000010);
      // Top of the array wraps to word 0, aliases read it back
      add_req(1'b1, 8'd3, 28'h00000fe);
      add_req(1'b0, 8'd3, 28'h00003fe);
      add_req(1'b0, 8'd2, 28'h8000100);

      // Six cycles per burst, plus sweep and slack per request
      budget = `DDR_MEM_WORDS + 100;
      foreach (plan_n[i])
         budget += 6 * int'(plan_n[i]) + 10;
      budget_cycles = budget;

      repeat (8) @(posedge CLK);
      #2;
      rst = 1'b0;
      foreach (plan_wr[i])
         run_request(plan_wr[i], plan_n[i], plan_addr[i]);
      repeat (4) @(negedge CLK);

      $display("checks %0d, value errors %0d, protocol errors %0d",
               checks, value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: list.f
+incdir+common
common/ddr_pkg.sv
ddr_ctrl/ddr_store.sv
ddr_ctrl/ddr_ctrl.sv
cmd_gen/cmd_gen.sv
hw/ddr_subsys.sv
verification/ddr_checker.sv
verification/ddr_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DDR subsystem testbench with Verilator, judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ddr_subsys_tb \
   -Mdir obj_dir -o sim_ddr -f list.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_ddr > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
   exit 0
fi
echo "Pass line not found in sim.log"
exit 1
